/* sim.f */
hw/xilinx_ram_pkg.sv
hw/stats_pkg.sv
hw/xilinx_ram_sdp_uram.sv
hw/stats_init.sv
hw/stats_update.sv
hw/stats_host_read.sv
hw/stats_table.sv
dv/stats_table_tb.sv

/* dv/stats_table_tb.sv */
/* Flow statistics table testbench
   Directed tests against a per-flow packet and byte reference model */
`timescale 1ns/1ps

module stats_table_tb;
    import stats_pkg::*;

    // ----------------------------------------
    // Test sizes and run budget
    // ----------------------------------------
    localparam int DRAIN_CYCLES  = TABLE_RD_LATENCY + 3;
    localparam int RD_WAIT_MAX   = 64;
    localparam int READ_COST     = RD_WAIT_MAX + 2;
    localparam int NUM_RAND      = 16;
    localparam int B2B_UPDATES   = 8 * (TABLE_RD_LATENCY + 1);
    localparam int MIX_UPDATES   = 30;
    localparam int BURST_LEN     = 24;
    localparam int CARRY_UPDATES = 65540;

    localparam int BUDGET_INIT    = NUM_FLOWS + 8 + NUM_RAND * READ_COST;
    localparam int BUDGET_SINGLE  = NUM_RAND * (1 + DRAIN_CYCLES + READ_COST);
    localparam int BUDGET_B2B     = B2B_UPDATES + DRAIN_CYCLES + READ_COST;
    localparam int BUDGET_MIX     = 2 * (MIX_UPDATES * 4 + DRAIN_CYCLES + 3 * READ_COST);
    localparam int BUDGET_TRAFFIC = BURST_LEN + 2 * DRAIN_CYCLES + 4 * READ_COST;
    localparam int BUDGET_FREEZE  = 16 + 3 * DRAIN_CYCLES + 5 * READ_COST;
    localparam int BUDGET_CARRY   = CARRY_UPDATES + DRAIN_CYCLES + READ_COST;
    localparam int WATCHDOG_CYCLES = 16 + 2 * (BUDGET_INIT + BUDGET_SINGLE + BUDGET_B2B
        + BUDGET_MIX + BUDGET_TRAFFIC + BUDGET_FREEZE + BUDGET_CARRY);

    logic                    clk;
    logic                    wr_srst;
    logic                    cnt_en;
    logic                    upd;
    logic [FLOW_ID_WID-1:0]  upd_id;
    logic [PKT_LEN_WID-1:0]  upd_bytes;
    logic                    rd_req;
    logic [FLOW_ID_WID-1:0]  rd_id;
    logic                    init_done;
    logic                    rd_valid;
    logic [PKT_CNT_WID-1:0]  rd_pkts;
    logic [BYTE_CNT_WID-1:0] rd_bytes;

    // Reference model
    logic [PKT_CNT_WID-1:0]  model_pkts  [NUM_FLOWS];
    logic [BYTE_CNT_WID-1:0] model_bytes [NUM_FLOWS];

    int err_cnt;
    int tests_run;
    int tests_failed;

    stats_table stats_table_inst (
        .clk       (clk),
        .wr_srst   (wr_srst),
        .cnt_en    (cnt_en),
        .init_done (init_done),
        .upd       (upd),
        .upd_id    (upd_id),
        .upd_bytes (upd_bytes),
        .rd_req    (rd_req),
        .rd_id     (rd_id),
        .rd_valid  (rd_valid),
        .rd_pkts   (rd_pkts),
        .rd_bytes  (rd_bytes)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic logic [FLOW_ID_WID-1:0] rand_flow();
        return FLOW_ID_WID'($urandom_range(NUM_FLOWS - 1, 0));
    endfunction

    function automatic logic [PKT_LEN_WID-1:0] rand_len();
        return PKT_LEN_WID'($urandom_range(2 ** PKT_LEN_WID - 1, 0));
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            upd    = 1'b0;
            rd_req = 1'b0;
        end
    endtask

    task automatic send_update(input logic [FLOW_ID_WID-1:0] id,
                               input logic [PKT_LEN_WID-1:0] len);
        @(negedge clk);
        upd       = 1'b1;
        upd_id    = id;
        upd_bytes = len;
        // Frozen table drops the write-back
        if (cnt_en) begin
            model_pkts[id]  = model_pkts[id] + 1'b1;
            model_bytes[id] = model_bytes[id] + BYTE_CNT_WID'(len);
        end
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic compare_pkts(input logic [FLOW_ID_WID-1:0] id,
                                input logic [PKT_CNT_WID-1:0] got,
                                input logic [PKT_CNT_WID-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error: rd_pkts flow 0x%0h got 0x%0h expected 0x%0h", id, got, exp);
        end
    endtask

    task automatic compare_bytes(input logic [FLOW_ID_WID-1:0]  id,
                                 input logic [BYTE_CNT_WID-1:0] got,
                                 input logic [BYTE_CNT_WID-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("error: rd_bytes flow 0x%0h got 0x%0h expected 0x%0h", id, got, exp);
        end
    endtask

    task automatic await_read(input logic [FLOW_ID_WID-1:0] id);
        int waited;
        waited = 0;
        while (!rd_valid && waited < RD_WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (!rd_valid) begin
            err_cnt++;
            $display("host read of flow 0x%0h got no rd_valid within %0d cycles", id, RD_WAIT_MAX);
        end else begin
            compare_pkts(id, rd_pkts, model_pkts[id]);
            compare_bytes(id, rd_bytes, model_bytes[id]);
        end
    endtask

    // One-cycle request strobe, then wait for the data
    task automatic read_check(input logic [FLOW_ID_WID-1:0] id);
        @(negedge clk);
        upd    = 1'b0;
        rd_req = 1'b1;
        rd_id  = id;
        @(negedge clk);
        rd_req = 1'b0;
        await_read(id);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt == err_before) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, err_cnt - err_before);
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_init_clears();
        int err_before;
        int waited;
        err_before = err_cnt;
        waited     = 0;
        if (init_done) begin
            err_cnt++;
            $display("init_done was already high straight after reset");
        end
        while (!init_done && waited < NUM_FLOWS + 8) begin
            @(negedge clk);
            waited++;
        end
        if (!init_done) begin
            err_cnt++;
            $display("init_done did not rise after the init sweep");
        end else begin
            for (int n = 0; n < NUM_RAND; n++) begin
                read_check(rand_flow());
            end
        end
        finish_test("init_clears", err_before);
    endtask

    task automatic test_single_updates();
        int err_before;
        logic [FLOW_ID_WID-1:0] id;
        err_before = err_cnt;
        for (int n = 0; n < NUM_RAND; n++) begin
            id = rand_flow();
            send_update(id, rand_len());
            idle_cycles(DRAIN_CYCLES);
            read_check(id);
        end
        finish_test("single_updates", err_before);
    endtask

    task automatic test_same_flow_b2b();
        int err_before;
        logic [FLOW_ID_WID-1:0] id;
        err_before = err_cnt;
        id = rand_flow();
        for (int n = 0; n < B2B_UPDATES; n++) begin
            send_update(id, rand_len());
        end
        idle_cycles(DRAIN_CYCLES);
        read_check(id);
        finish_test("same_flow_b2b", err_before);
    endtask

    task automatic test_interleaved();
        int err_before;
        logic [FLOW_ID_WID-1:0] flows [3];
        err_before = err_cnt;
        flows[0] = rand_flow();
        flows[1] = flows[0] ^ FLOW_ID_WID'(1);
        flows[2] = flows[0] ^ FLOW_ID_WID'(2);
        // Two then three flows, random gaps of 0 to 3 cycles
        for (int k = 2; k <= 3; k++) begin
            for (int n = 0; n < MIX_UPDATES; n++) begin
                send_update(flows[n % k], rand_len());
                idle_cycles($urandom_range(3, 0));
            end
            idle_cycles(DRAIN_CYCLES);
            for (int i = 0; i < k; i++) begin
                read_check(flows[i]);
            end
        end
        finish_test("interleaved", err_before);
    endtask

    task automatic test_read_under_traffic();
        int err_before;
        logic [FLOW_ID_WID-1:0] rd_flow;
        logic [FLOW_ID_WID-1:0] busy [2];
        err_before = err_cnt;
        rd_flow = rand_flow();
        busy[0] = rd_flow ^ FLOW_ID_WID'(1);
        busy[1] = rd_flow ^ FLOW_ID_WID'(2);
        send_update(rd_flow, rand_len());
        idle_cycles(DRAIN_CYCLES);
        for (int n = 0; n < BURST_LEN; n++) begin
            send_update(busy[n % 2], rand_len());
            rd_req = (n == 4);
            rd_id  = rd_flow;
            if (rd_valid) begin
                err_cnt++;
                $display("rd_valid pulsed while updates held the read port");
            end
        end
        // First free slot lets the pending read out
        idle_cycles(1);
        await_read(rd_flow);
        idle_cycles(DRAIN_CYCLES);
        read_check(busy[0]);
        read_check(busy[1]);
        finish_test("read_under_traffic", err_before);
    endtask

    task automatic test_counting_freeze();
        int err_before;
        logic [FLOW_ID_WID-1:0] frz [2];
        err_before = err_cnt;
        frz[0] = rand_flow();
        frz[1] = frz[0] ^ FLOW_ID_WID'(1);
        send_update(frz[0], rand_len());
        idle_cycles(DRAIN_CYCLES);
        read_check(frz[0]);
        idle_cycles(1);
        cnt_en = 1'b0;
        for (int n = 0; n < 8; n++) begin
            send_update(frz[n % 2], rand_len());
        end
        // Hold the freeze until the last write-back has gone by
        idle_cycles(DRAIN_CYCLES);
        cnt_en = 1'b1;
        read_check(frz[0]);
        read_check(frz[1]);
        for (int n = 0; n < 6; n++) begin
            send_update(frz[n % 2], rand_len());
        end
        idle_cycles(DRAIN_CYCLES);
        read_check(frz[0]);
        read_check(frz[1]);
        finish_test("counting_freeze", err_before);
    endtask

    task automatic test_byte_carry();
        int err_before;
        logic [FLOW_ID_WID-1:0] id;
        err_before = err_cnt;
        id = rand_flow();
        for (int n = 0; n < CARRY_UPDATES; n++) begin
            send_update(id, {PKT_LEN_WID{1'b1}});
        end
        idle_cycles(DRAIN_CYCLES);
        read_check(id);
        finish_test("byte_carry", err_before);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'h9337));
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        wr_srst      = 1'b1;
        cnt_en       = 1'b1;
        upd          = 1'b0;
        upd_id       = '0;
        upd_bytes    = '0;
        rd_req       = 1'b0;
        rd_id        = '0;
        for (int i = 0; i < NUM_FLOWS; i++) begin
            model_pkts[i]  = '0;
            model_bytes[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        wr_srst = 1'b0;

        test_init_clears();
        test_single_updates();
        test_same_flow_b2b();
        test_interleaved();
        test_read_under_traffic();
        test_counting_freeze();
        test_byte_carry();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : stats_table_tb

/* hw/stats_table.sv */
/* Per-flow statistics table
   Packet and byte counters per flow in UltraRAM, with init sweep and host reads */
`timescale 1ns/1ps

module stats_table (
    input  logic                               clk,
    input  logic                               wr_srst,
    input  logic                               cnt_en,
    output logic                               init_done,

    // Counter updates
    input  logic                               upd,
    input  logic [stats_pkg::FLOW_ID_WID-1:0]  upd_id,
    input  logic [stats_pkg::PKT_LEN_WID-1:0]  upd_bytes,

    // Host reads
    input  logic                               rd_req,
    input  logic [stats_pkg::FLOW_ID_WID-1:0]  rd_id,
    output logic                               rd_valid,
    output logic [stats_pkg::PKT_CNT_WID-1:0]  rd_pkts,
    output logic [stats_pkg::BYTE_CNT_WID-1:0] rd_bytes
);
    import stats_pkg::*;

    // ----------------------------------------
    // Internal wires
    // ----------------------------------------
    logic                   init_wr;
    logic [FLOW_ID_WID-1:0] init_addr;
    logic                   upd_issue;
    logic                   host_rd_en;
    logic [FLOW_ID_WID-1:0] host_rd_addr;
    logic                   ram_rd_en;
    logic [FLOW_ID_WID-1:0] ram_rd_addr;
    logic [ENTRY_WID-1:0]   ram_rd_data;
    logic                   ram_wr_req;
    logic [FLOW_ID_WID-1:0] ram_wr_addr;
    logic [ENTRY_WID-1:0]   ram_wr_data;

    // ----------------------------------------
    // Instances
    // ----------------------------------------
    stats_init stats_init_inst (
        .clk       (clk),
        .wr_srst   (wr_srst),
        .init_wr   (init_wr),
        .init_addr (init_addr),
        .init_done (init_done)
    );

    stats_update stats_update_inst (
        .clk          (clk),
        .wr_srst      (wr_srst),
        .cnt_en       (cnt_en),
        .init_done    (init_done),
        .init_wr      (init_wr),
        .init_addr    (init_addr),
        .upd          (upd),
        .upd_id       (upd_id),
        .upd_bytes    (upd_bytes),
        .host_rd_en   (host_rd_en),
        .host_rd_addr (host_rd_addr),
        .upd_issue    (upd_issue),
        .ram_rd_data  (ram_rd_data),
        .ram_rd_en    (ram_rd_en),
        .ram_rd_addr  (ram_rd_addr),
        .ram_wr_req   (ram_wr_req),
        .ram_wr_addr  (ram_wr_addr),
        .ram_wr_data  (ram_wr_data)
    );

    stats_host_read stats_host_read_inst (
        .clk          (clk),
        .wr_srst      (wr_srst),
        .init_done    (init_done),
        .upd_issue    (upd_issue),
        .rd_req       (rd_req),
        .rd_id        (rd_id),
        .rd_valid     (rd_valid),
        .rd_pkts      (rd_pkts),
        .rd_bytes     (rd_bytes),
        .ram_rd_data  (ram_rd_data),
        .host_rd_en   (host_rd_en),
        .host_rd_addr (host_rd_addr)
    );

    // Global counting enable gates every write
    xilinx_ram_sdp_uram #(
        .ADDR_WID (FLOW_ID_WID),
        .DATA_WID (ENTRY_WID),
        .OPT_MODE (TABLE_OPT_MODE)
    ) xilinx_ram_sdp_uram_inst (
        .clk     (clk),
        .wr_srst (wr_srst),
        .wr_en   (cnt_en),
        .wr_req  (ram_wr_req),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .rd_en   (ram_rd_en),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

endmodule : stats_table

/* hw/stats_host_read.sv */
/* Host read port
   Waits for a free RAM read slot, returns both counters with a valid pulse */
`timescale 1ns/1ps

module stats_host_read (
    input  logic                               clk,
    input  logic                               wr_srst,
    input  logic                               init_done,
    input  logic                               upd_issue,

    // Host side
    input  logic                               rd_req,
    input  logic [stats_pkg::FLOW_ID_WID-1:0]  rd_id,
    output logic                               rd_valid,
    output logic [stats_pkg::PKT_CNT_WID-1:0]  rd_pkts,
    output logic [stats_pkg::BYTE_CNT_WID-1:0] rd_bytes,

    // RAM side
    input  logic [stats_pkg::ENTRY_WID-1:0]    ram_rd_data,
    output logic                               host_rd_en,
    output logic [stats_pkg::FLOW_ID_WID-1:0]  host_rd_addr
);
    import stats_pkg::*;

    logic                   req_ok;
    logic                   pend;
    logic [FLOW_ID_WID-1:0] pend_id;
    logic                   lat_vld [TABLE_RD_LATENCY];

    // ----------------------------------------
    // Request capture and issue
    // ----------------------------------------
    assign req_ok       = rd_req && init_done;
    // A new request may issue in its own cycle if the port is free
    assign host_rd_en   = (pend || req_ok) && !upd_issue;
    assign host_rd_addr = pend ? pend_id : rd_id;

    always_ff @(posedge clk) begin
        if (wr_srst) begin
            pend <= 1'b0;
        end else if (host_rd_en) begin
            pend <= 1'b0;
        end else if (req_ok) begin
            pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_ok && !pend) pend_id <= rd_id;
    end

    // ----------------------------------------
    // Return
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr_srst) begin
            for (int i = 0; i < TABLE_RD_LATENCY; i++) begin
                lat_vld[i] <= 1'b0;
            end
        end else begin
            lat_vld[0] <= host_rd_en;
            for (int i = 1; i < TABLE_RD_LATENCY; i++) begin
                lat_vld[i] <= lat_vld[i-1];
            end
        end
    end

    assign rd_valid = lat_vld[TABLE_RD_LATENCY-1];
    assign rd_pkts  = ram_rd_data[ENTRY_WID-1 -: PKT_CNT_WID];
    assign rd_bytes = ram_rd_data[BYTE_CNT_WID-1:0];

endmodule : stats_host_read

/* hw/stats_update.sv */
/* Counter update pipeline
   Read-modify-write with in-flight forwarding; also owns the RAM port muxes */
`timescale 1ns/1ps

module stats_update (
    input  logic                              clk,
    input  logic                              wr_srst,
    input  logic                              cnt_en,

    // Init sweep
    input  logic                              init_done,
    input  logic                              init_wr,
    input  logic [stats_pkg::FLOW_ID_WID-1:0] init_addr,

    // Update strobe
    input  logic                              upd,
    input  logic [stats_pkg::FLOW_ID_WID-1:0] upd_id,
    input  logic [stats_pkg::PKT_LEN_WID-1:0] upd_bytes,

    // Host read request
    input  logic                              host_rd_en,
    input  logic [stats_pkg::FLOW_ID_WID-1:0] host_rd_addr,
    output logic                              upd_issue,

    // RAM ports
    input  logic [stats_pkg::ENTRY_WID-1:0]   ram_rd_data,
    output logic                              ram_rd_en,
    output logic [stats_pkg::FLOW_ID_WID-1:0] ram_rd_addr,
    output logic                              ram_wr_req,
    output logic [stats_pkg::FLOW_ID_WID-1:0] ram_wr_addr,
    output logic [stats_pkg::ENTRY_WID-1:0]   ram_wr_data
);
    import xilinx_ram_pkg::*;
    import stats_pkg::*;

    // ----------------------------------------
    // Parameters
    // ----------------------------------------
    localparam int RD_LAT = TABLE_RD_LATENCY;
    // Write-backs issued since the oldest outstanding read, excluding the current one
    localparam int FWD_DEPTH = get_uram_rd_pipeline_stages(FLOW_ID_WID, TABLE_OPT_MODE) + 1;

    // ----------------------------------------
    // Signals
    // ----------------------------------------
    logic                   p_vld   [RD_LAT];
    logic [FLOW_ID_WID-1:0] p_id    [RD_LAT];
    logic [PKT_LEN_WID-1:0] p_bytes [RD_LAT];

    logic                   wb_vld;
    logic [FLOW_ID_WID-1:0] wb_id;
    logic [ENTRY_WID-1:0]   wb_data;

    logic                   hist_vld  [FWD_DEPTH];
    logic [FLOW_ID_WID-1:0] hist_id   [FWD_DEPTH];
    logic [ENTRY_WID-1:0]   hist_data [FWD_DEPTH];

    logic                    fwd_hit;
    logic [ENTRY_WID-1:0]    fwd_data;
    logic [ENTRY_WID-1:0]    base;
    logic [PKT_CNT_WID-1:0]  sum_pkts;
    logic [BYTE_CNT_WID-1:0] sum_bytes;

    // ----------------------------------------
    // Port muxes
    // ----------------------------------------
    assign upd_issue   = upd && init_done;
    assign ram_rd_en   = upd_issue || host_rd_en;
    assign ram_rd_addr = upd_issue ? upd_id : host_rd_addr;

    assign ram_wr_req  = init_done ? wb_vld : init_wr;
    assign ram_wr_addr = init_done ? wb_id : init_addr;
    assign ram_wr_data = init_done ? wb_data : '0;

    // ----------------------------------------
    // Update tracking alongside the RAM read
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr_srst) begin
            for (int i = 0; i < RD_LAT; i++) begin
                p_vld[i] <= 1'b0;
            end
        end else begin
            p_vld[0] <= upd_issue;
            for (int i = 1; i < RD_LAT; i++) begin
                p_vld[i] <= p_vld[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        p_id[0]    <= upd_id;
        p_bytes[0] <= upd_bytes;
        for (int i = 1; i < RD_LAT; i++) begin
            p_id[i]    <= p_id[i-1];
            p_bytes[i] <= p_bytes[i-1];
        end
    end

    // ----------------------------------------
    // Forwarding
    // ----------------------------------------
    // Oldest first so fresher matches overwrite
    always_comb begin
        fwd_hit  = 1'b0;
        fwd_data = '0;
        for (int i = FWD_DEPTH - 1; i >= 0; i--) begin
            if (hist_vld[i] && hist_id[i] == p_id[RD_LAT-1]) begin
                fwd_hit  = 1'b1;
                fwd_data = hist_data[i];
            end
        end
        // Write-back going out this cycle only counts if the RAM takes it
        if (wb_vld && cnt_en && wb_id == p_id[RD_LAT-1]) begin
            fwd_hit  = 1'b1;
            fwd_data = wb_data;
        end
    end

    assign base      = fwd_hit ? fwd_data : ram_rd_data;
    assign sum_pkts  = base[ENTRY_WID-1 -: PKT_CNT_WID] + 1'b1;
    assign sum_bytes = base[BYTE_CNT_WID-1:0] + BYTE_CNT_WID'(p_bytes[RD_LAT-1]);

    // ----------------------------------------
    // Write-back and history
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr_srst) begin
            wb_vld <= 1'b0;
            for (int i = 0; i < FWD_DEPTH; i++) begin
                hist_vld[i] <= 1'b0;
            end
        end else begin
            wb_vld      <= p_vld[RD_LAT-1];
            hist_vld[0] <= wb_vld && cnt_en;
            for (int i = 1; i < FWD_DEPTH; i++) begin
                hist_vld[i] <= hist_vld[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_id        <= p_id[RD_LAT-1];
        wb_data      <= {sum_pkts, sum_bytes};
        hist_id[0]   <= wb_id;
        hist_data[0] <= wb_data;
        for (int i = 1; i < FWD_DEPTH; i++) begin
            hist_id[i]   <= hist_id[i-1];
            hist_data[i] <= hist_data[i-1];
        end
    end

endmodule : stats_update

/* hw/stats_init.sv */
/* Flow table init sweeper
   Writes zero to every entry once after reset, then flags completion */
`timescale 1ns/1ps

module stats_init (
    input  logic                             clk,
    input  logic                             wr_srst,
    output logic                             init_wr,
    output logic [stats_pkg::FLOW_ID_WID-1:0] init_addr,
    output logic                             init_done
);
    import stats_pkg::*;

    localparam logic [FLOW_ID_WID-1:0] LAST_ADDR = FLOW_ID_WID'(NUM_FLOWS - 1);

    // ----------------------------------------
    // Sweep counter
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr_srst) begin
            init_wr   <= 1'b0;
            init_addr <= '0;
            init_done <= 1'b0;
        end else if (init_wr) begin
            init_addr <= init_addr + 1'b1;
            // Last entry written this cycle
            if (init_addr == LAST_ADDR) begin
                init_wr   <= 1'b0;
                init_done <= 1'b1;
            end
        end else if (!init_done) begin
            // Kick off the sweep on the first cycle out of reset
            init_wr <= 1'b1;
        end
    end

endmodule : stats_init

/* hw/xilinx_ram_sdp_uram.sv */
/* Simple dual-port UltraRAM
   Write port with global enable, read port with configurable output pipeline */
`timescale 1ns/1ps

module xilinx_ram_sdp_uram #(
    parameter int ADDR_WID = 8,
    parameter int DATA_WID = 32,
    parameter xilinx_ram_pkg::opt_mode_t OPT_MODE = xilinx_ram_pkg::OPT_MODE_TIMING
) (
    input  logic                clk,
    input  logic                wr_srst,

    // Write port
    input  logic                wr_en,
    input  logic                wr_req,
    input  logic [ADDR_WID-1:0] wr_addr,
    input  logic [DATA_WID-1:0] wr_data,

    // Read port
    input  logic                rd_en,
    input  logic [ADDR_WID-1:0] rd_addr,
    output logic [DATA_WID-1:0] rd_data
);
    import xilinx_ram_pkg::*;

    // ----------------------------------------
    // Parameters
    // ----------------------------------------
    localparam int DEPTH          = 2 ** ADDR_WID;
    localparam int RD_PIPE_STAGES = get_uram_rd_pipeline_stages(ADDR_WID, OPT_MODE);

    // ----------------------------------------
    // Array
    // ----------------------------------------
    (* ram_style = "ultra" *) logic [DATA_WID-1:0] mem [DEPTH];

    logic [DATA_WID-1:0] rd_data_q;

    // Write is dropped unless the global enable is set
    always_ff @(posedge clk) begin
        if (wr_en && wr_req) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read-first: a same-cycle write is not seen
    always_ff @(posedge clk) begin
        if (wr_srst) begin
            rd_data_q <= '0;
        end else if (rd_en) begin
            rd_data_q <= mem[rd_addr];
        end
    end

    // ----------------------------------------
    // Read pipeline
    // ----------------------------------------
    generate
        if (RD_PIPE_STAGES > 0) begin : g_rd_pipe
            logic                rd_en_p   [RD_PIPE_STAGES];
            logic [DATA_WID-1:0] rd_data_p [RD_PIPE_STAGES];

            // Enables follow the data so each stage loads only on a real read
            always_ff @(posedge clk) begin
                if (wr_srst) begin
                    for (int i = 0; i < RD_PIPE_STAGES; i++) begin
                        rd_en_p[i] <= 1'b0;
                    end
                end else begin
                    rd_en_p[0] <= rd_en;
                    for (int i = 1; i < RD_PIPE_STAGES; i++) begin
                        rd_en_p[i] <= rd_en_p[i-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                if (rd_en_p[0]) rd_data_p[0] <= rd_data_q;
                for (int i = 1; i < RD_PIPE_STAGES; i++) begin
                    if (rd_en_p[i]) rd_data_p[i] <= rd_data_p[i-1];
                end
            end

            assign rd_data = rd_data_p[RD_PIPE_STAGES-1];
        end else begin : g_rd_direct
            assign rd_data = rd_data_q;
        end
    endgenerate

endmodule : xilinx_ram_sdp_uram

/* hw/stats_pkg.sv */
/* Flow statistics package
   Table sizes, counter widths and memory configuration */
package stats_pkg;

    // ----------------------------------------
    // Flow table
    // ----------------------------------------
    localparam int FLOW_ID_WID = 10;
    localparam int NUM_FLOWS   = 2 ** FLOW_ID_WID;

    // ----------------------------------------
    // Counters
    // ----------------------------------------
    localparam int PKT_CNT_WID  = 32;
    localparam int BYTE_CNT_WID = 48;
    localparam int PKT_LEN_WID  = 16;

    // Entry layout is {packets, bytes}, bytes in the low bits
    localparam int ENTRY_WID = PKT_CNT_WID + BYTE_CNT_WID;

    // ----------------------------------------
    // Memory
    // ----------------------------------------
    localparam xilinx_ram_pkg::opt_mode_t TABLE_OPT_MODE = xilinx_ram_pkg::OPT_MODE_TIMING;

    // Array register plus the extra read stages
    localparam int TABLE_RD_LATENCY =
        1 + xilinx_ram_pkg::get_uram_rd_pipeline_stages(FLOW_ID_WID, TABLE_OPT_MODE);

endpackage : stats_pkg

/* hw/xilinx_ram_pkg.sv */
/* Xilinx RAM support package
   Memory optimisation modes and UltraRAM read pipeline sizing */
package xilinx_ram_pkg;

    // ----------------------------------------
    // Constants
    // ----------------------------------------
    // Address width of one UltraRAM block (4K deep)
    localparam int URAM_BLOCK_ADDR_WID = 12;

    // Extra read register stages per configuration
    localparam int URAM_PIPE_STAGES_LATENCY = 0;
    localparam int URAM_PIPE_STAGES_SINGLE  = 1;
    localparam int URAM_PIPE_STAGES_CASCADE = 2;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef enum logic {
        OPT_MODE_LATENCY,
        OPT_MODE_TIMING
    } opt_mode_t;

    // ----------------------------------------
    // Functions
    // ----------------------------------------
    // Read register stages after the array output register
    function automatic int get_uram_rd_pipeline_stages(
        input int        addr_wid,
        input opt_mode_t opt_mode
    );
        int stages;
        case (opt_mode)
            OPT_MODE_LATENCY: stages = URAM_PIPE_STAGES_LATENCY;
            default: begin
                // Deeper arrays cascade several blocks
                if (addr_wid <= URAM_BLOCK_ADDR_WID) begin
                    stages = URAM_PIPE_STAGES_SINGLE;
                end else begin
                    stages = URAM_PIPE_STAGES_CASCADE;
                end
            end
        endcase
        return stages;
    endfunction

endpackage : xilinx_ram_pkg
